/* hw/fifo_geom_pkg.sv */
// fifo geometry definitions

package fifo_geom_pkg;

   // ------------------------------------------------------------------
   // sizes
   // ------------------------------------------------------------------
   localparam int DATA_W = 8;                // bits per stored word
   localparam int DEPTH  = 16;               // number of entries
   localparam int ADDR_W = $clog2(DEPTH);    // 4 bits, wraps at DEPTH
   localparam int CNT_W  = ADDR_W + 1;       // one extra bit so count can hold DEPTH

   // ------------------------------------------------------------------
   // types
   // ------------------------------------------------------------------

   // one word of payload
   typedef logic [DATA_W-1:0] data_t;

   // storage index, used for both write and read addresses
   typedef logic [ADDR_W-1:0] addr_t;

   // occupancy, 0 .. DEPTH
   typedef logic [CNT_W-1:0]  count_t;

   // last valid address before wrap
   localparam addr_t LAST_ADDR = addr_t'(DEPTH - 1);

   // full level as a count value
   localparam count_t FULL_CNT = count_t'(DEPTH);

endpackage

/* hw/fifo_flag_pkg.sv */
// fifo status and handshake definitions

package fifo_flag_pkg;

   // ------------------------------------------------------------------
   // static thresholds
   // ------------------------------------------------------------------

   // afull asserts at or above this level
   localparam fifo_geom_pkg::count_t AFULL_VAL  = fifo_geom_pkg::count_t'(14);

   // aempty asserts at or below this level
   localparam fifo_geom_pkg::count_t AEMPTY_VAL = fifo_geom_pkg::count_t'(2);

   // ------------------------------------------------------------------
   // four-phase handshake state, shared by write and read side
   // ------------------------------------------------------------------
   typedef enum logic [1:0] {
      HS_IDLE = 2'd0,   // waiting for a request
      HS_ACK  = 2'd1,   // ack high, waiting for request to drop
      HS_DONE = 2'd2    // ack low again, one settle cycle before idle
   } hs_state_t;

endpackage

/* hw/wr_port_ctrl.sv */
// fifo write side handshake
`timescale 1ns/1ps

module wr_port_ctrl (
   input  logic                 pos_clk,
   input  logic                 aresetn,
   input  logic                 wr_req_i,     // four-phase request from source
   input  fifo_geom_pkg::data_t wr_data_i,    // stable while wr_req_i high
   input  logic                 full_i,       // back-pressure from store
   output logic                 wr_ack_o,
   output logic                 push_o,       // one cycle per accepted write
   output fifo_geom_pkg::data_t push_data_o
);

   fifo_flag_pkg::hs_state_t state_q;
   fifo_flag_pkg::hs_state_t state_d;
   logic                     accept;

   // ------------------------------------------------------------------
   // accept condition
   // ------------------------------------------------------------------

   // only place that looks at full
   assign accept = (state_q == fifo_flag_pkg::HS_IDLE) && wr_req_i && !full_i;

   assign push_o      = accept;
   assign push_data_o = wr_data_i;   // source holds data until ack

   // ------------------------------------------------------------------
   // handshake fsm
   // ------------------------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         fifo_flag_pkg::HS_IDLE: begin
            if (accept)
               state_d = fifo_flag_pkg::HS_ACK;   // word goes into store now
         end
         fifo_flag_pkg::HS_ACK: begin
            // hold ack until the source lets go
            if (!wr_req_i)
               state_d = fifo_flag_pkg::HS_DONE;
         end
         fifo_flag_pkg::HS_DONE: begin
            state_d = fifo_flag_pkg::HS_IDLE;     // ack already low
         end
         default: begin
            state_d = fifo_flag_pkg::HS_IDLE;     // unused code, recover
         end
      endcase
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         state_q <= fifo_flag_pkg::HS_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // ack is a pure state decode, high for the whole HS_ACK phase
   assign wr_ack_o = (state_q == fifo_flag_pkg::HS_ACK);

endmodule

/* hw/fifo_store.sv */
// counter based fifo buffer
`timescale 1ns/1ps

module fifo_store (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  push_i,        // never high while full
   input  fifo_geom_pkg::data_t  push_data_i,
   input  logic                  pop_i,         // never high while empty
   output fifo_geom_pkg::data_t  pop_data_o,    // changes only on a pop
   output fifo_geom_pkg::count_t count_o,
   output logic                  full_o,
   output logic                  afull_o,
   output logic                  empty_o,
   output logic                  aempty_o
);

   // storage, no reset on payload
   fifo_geom_pkg::data_t  mem [fifo_geom_pkg::DEPTH];

   fifo_geom_pkg::addr_t  waddr_q;       // next slot to write
   fifo_geom_pkg::addr_t  raddr_q;       // oldest word
   fifo_geom_pkg::count_t cnt_q;         // occupancy
   fifo_geom_pkg::count_t cnt_nxt;       // occupancy after this edge
   fifo_geom_pkg::data_t  pop_data_q;

   logic full_q;
   logic afull_q;
   logic empty_q;
   logic aempty_q;
   logic cnt_upd;                        // push and pop differ

   // ------------------------------------------------------------------
   // storage array
   // ------------------------------------------------------------------
   always_ff @(posedge pos_clk) begin
      if (push_i)
         mem[waddr_q] <= push_data_i;
   end

   // registered read port, loaded on pop only
   always_ff @(posedge pos_clk) begin
      if (pop_i)
         pop_data_q <= mem[raddr_q];
   end

   assign pop_data_o = pop_data_q;

   // ------------------------------------------------------------------
   // write and read addresses, each wraps at DEPTH
   // ------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         waddr_q <= '0;
      end else if (push_i) begin
         if (waddr_q == fifo_geom_pkg::LAST_ADDR)
            waddr_q <= '0;
         else
            waddr_q <= waddr_q + 1'b1;
      end
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         raddr_q <= '0;
      end else if (pop_i) begin
         if (raddr_q == fifo_geom_pkg::LAST_ADDR)
            raddr_q <= '0;
         else
            raddr_q <= raddr_q + 1'b1;
      end
   end

   // ------------------------------------------------------------------
   // occupancy counter
   // ------------------------------------------------------------------
   assign cnt_upd = push_i ^ pop_i;      // both at once: level unchanged

   always_comb begin
      cnt_nxt = cnt_q;
      if (push_i && !pop_i)
         cnt_nxt = cnt_q + fifo_geom_pkg::count_t'(1);   // up on write
      else if (pop_i && !push_i)
         cnt_nxt = cnt_q - fifo_geom_pkg::count_t'(1);   // down on read
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         cnt_q <= '0;
      end else if (cnt_upd) begin
         cnt_q <= cnt_nxt;
      end
   end

   assign count_o = cnt_q;

   // ------------------------------------------------------------------
   // status flags
   // ------------------------------------------------------------------

   // flags come from the next count, so they line up with count_o
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_q   <= 1'b0;
         afull_q  <= 1'b0;
         empty_q  <= 1'b1;     // empty out of reset
         aempty_q <= 1'b1;
      end else if (cnt_upd) begin
         full_q   <= (cnt_nxt == fifo_geom_pkg::FULL_CNT);
         afull_q  <= (cnt_nxt >= fifo_flag_pkg::AFULL_VAL);
         empty_q  <= (cnt_nxt == '0);
         aempty_q <= (cnt_nxt <= fifo_flag_pkg::AEMPTY_VAL);
      end
   end

   assign full_o   = full_q;
   assign afull_o  = afull_q;
   assign empty_o  = empty_q;
   assign aempty_o = aempty_q;

endmodule

/* hw/rd_port_ctrl.sv */
// fifo read side handshake
`timescale 1ns/1ps

module rd_port_ctrl (
   input  logic                 pos_clk,
   input  logic                 aresetn,
   input  logic                 rd_req_i,     // four-phase request from sink
   input  logic                 empty_i,      // back-pressure from store
   input  fifo_geom_pkg::data_t pop_data_i,   // registered in store on pop
   output logic                 rd_ack_o,     // rd_data_o valid while high
   output logic                 pop_o,        // one cycle per accepted read
   output fifo_geom_pkg::data_t rd_data_o
);

   fifo_flag_pkg::hs_state_t state_q;
   fifo_flag_pkg::hs_state_t state_d;
   logic                     accept;

   // ------------------------------------------------------------------
   // accept condition
   // ------------------------------------------------------------------

   // a read on an empty fifo just waits here
   assign accept = (state_q == fifo_flag_pkg::HS_IDLE) && rd_req_i && !empty_i;

   assign pop_o = accept;

   // store holds this register until the next pop,
   // and no pop can happen before the ack has dropped
   assign rd_data_o = pop_data_i;

   // ------------------------------------------------------------------
   // handshake fsm
   // ------------------------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         fifo_flag_pkg::HS_IDLE: begin
            if (accept)
               state_d = fifo_flag_pkg::HS_ACK;   // data lands in pop register
         end
         fifo_flag_pkg::HS_ACK: begin
            if (!rd_req_i)
               state_d = fifo_flag_pkg::HS_DONE;  // sink has taken the word
         end
         fifo_flag_pkg::HS_DONE: begin
            state_d = fifo_flag_pkg::HS_IDLE;
         end
         default: begin
            state_d = fifo_flag_pkg::HS_IDLE;
         end
      endcase
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         state_q <= fifo_flag_pkg::HS_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // ack visible the cycle after the accept edge
   assign rd_ack_o = (state_q == fifo_flag_pkg::HS_ACK);

endmodule

/* hw/scntr_fifo_top.sv */
// synchronous counter fifo top
`timescale 1ns/1ps

module scntr_fifo_top (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  wr_req_i,
   input  fifo_geom_pkg::data_t  wr_data_i,
   input  logic                  rd_req_i,
   output logic                  wr_ack_o,
   output logic                  rd_ack_o,
   output fifo_geom_pkg::data_t  rd_data_o,
   output fifo_geom_pkg::count_t count_o,
   output logic                  full_o,
   output logic                  afull_o,
   output logic                  empty_o,
   output logic                  aempty_o
);

   // producer to buffer
   logic                 push;
   fifo_geom_pkg::data_t push_data;

   // buffer to consumer
   logic                 pop;
   fifo_geom_pkg::data_t pop_data;

   // ------------------------------------------------------------------
   // write side
   // ------------------------------------------------------------------
   wr_port_ctrl u_wr_port_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_req_i    (wr_req_i),
      .wr_data_i   (wr_data_i),
      .full_i      (full_o),      // full flag doubles as write back-pressure
      .wr_ack_o    (wr_ack_o),
      .push_o      (push),
      .push_data_o (push_data)
   );

   // buffer, counter and flags
   fifo_store u_fifo_store (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .push_i      (push),
      .push_data_i (push_data),
      .pop_i       (pop),
      .pop_data_o  (pop_data),
      .count_o     (count_o),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o)
   );

   // ------------------------------------------------------------------
   // read side
   // ------------------------------------------------------------------
   rd_port_ctrl u_rd_port_ctrl (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .rd_req_i   (rd_req_i),
      .empty_i    (empty_o),      // read waits while empty
      .pop_data_i (pop_data),
      .rd_ack_o   (rd_ack_o),
      .pop_o      (pop),
      .rd_data_o  (rd_data_o)
   );

endmodule

/* sim/tb_clkgen.sv */
// testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen (
   output logic pos_clk,
   output logic aresetn
);

   localparam int CLK_PERIOD = 40;     // ns
   localparam int RST_CYC    = 3;      // cycles held in reset

   // free running clock, starts low
   initial begin
      pos_clk = 1'b0;
      forever #(CLK_PERIOD / 2) pos_clk = ~pos_clk;
   end

   // release a little after an edge, away from the sampling point
   initial begin
      aresetn = 1'b0;
      repeat (RST_CYC) @(posedge pos_clk);
      #2;
      aresetn = 1'b1;
   end

endmodule

/* sim/tb_scntr_fifo.sv */
// counter fifo testbench
`timescale 1ns/1ps

module tb_scntr_fifo;

   // ------------------------------------------------------------------
   // run lengths, all in clock cycles unless noted
   // ------------------------------------------------------------------
   localparam int CLK_PERIOD  = 40;      // ns, same as tb_clkgen
   localparam int DRV_DLY     = 2;       // ns after rising edge
   localparam int N_RAND      = 100;     // words in the random phase
   localparam int GAP_MAX     = 3;       // idle cycles between requests
   localparam int HS_CYC      = 6;       // one handshake, no back-pressure
   localparam int HOLD_CYC    = 10;      // blocked request held this long
   localparam int RAND_CYC    = 2 * N_RAND * (HS_CYC + GAP_MAX);
   localparam int FULL_CYC    = (2 * fifo_geom_pkg::DEPTH + 2) * HS_CYC + HOLD_CYC;
   localparam int EMPTY_CYC   = 2 * HS_CYC + HOLD_CYC;
   localparam int TOTAL_CYC   = 3 + RAND_CYC + FULL_CYC + EMPTY_CYC + 8;
   localparam int WATCHDOG_NS = TOTAL_CYC * CLK_PERIOD * 3 / 2;

   logic                  pos_clk;
   logic                  aresetn;
   logic                  wr_req_i;
   fifo_geom_pkg::data_t  wr_data_i;
   logic                  rd_req_i;
   logic                  wr_ack_o;
   logic                  rd_ack_o;
   fifo_geom_pkg::data_t  rd_data_o;
   fifo_geom_pkg::count_t count_o;
   logic                  full_o;
   logic                  afull_o;
   logic                  empty_o;
   logic                  aempty_o;

   int value_errs = 0;
   int proto_errs = 0;
   int other_errs = 0;
   int seed       = 70278;

   // reference model
   fifo_geom_pkg::data_t model_q [$];
   fifo_geom_pkg::data_t exp_word;
   int                   model_cnt = 0;   // occupancy after last edge
   logic                 prev_wr_ack = 1'b0;
   logic                 prev_rd_ack = 1'b0;
   bit                   seen_cnt [0:fifo_geom_pkg::DEPTH];

   tb_clkgen u_clkgen (.pos_clk(pos_clk), .aresetn(aresetn));

   scntr_fifo_top dut_i (
      .pos_clk(pos_clk), .aresetn(aresetn),
      .wr_req_i(wr_req_i), .wr_data_i(wr_data_i), .rd_req_i(rd_req_i),
      .wr_ack_o(wr_ack_o), .rd_ack_o(rd_ack_o), .rd_data_o(rd_data_o),
      .count_o(count_o), .full_o(full_o), .afull_o(afull_o),
      .empty_o(empty_o), .aempty_o(aempty_o)
   );

   task automatic value_error(input string msg);
      value_errs++;
      $display("error at %0t ns: %s", $time, msg);
   endtask

   task automatic protocol_error(input string msg);
      proto_errs++;
      $display("error at %0t ns: %s", $time, msg);
   endtask

   // ------------------------------------------------------------------
   // port assertions, sampled at the rising edge
   // ------------------------------------------------------------------
   a_wr_rise: assert property (@(posedge pos_clk) disable iff (!aresetn)
      $rose(wr_ack_o) |-> $past(wr_req_i)) else protocol_error("wr_ack_o rose without request");
   a_wr_fall: assert property (@(posedge pos_clk) disable iff (!aresetn)
      $fell(wr_ack_o) |-> !$past(wr_req_i)) else protocol_error("wr_ack_o fell while requested");
   a_rd_rise: assert property (@(posedge pos_clk) disable iff (!aresetn)
      $rose(rd_ack_o) |-> $past(rd_req_i)) else protocol_error("rd_ack_o rose without request");
   a_rd_fall: assert property (@(posedge pos_clk) disable iff (!aresetn)
      $fell(rd_ack_o) |-> !$past(rd_req_i)) else protocol_error("rd_ack_o fell while requested");
   a_no_ovf: assert property (@(posedge pos_clk) disable iff (!aresetn)
      $rose(wr_ack_o) |-> !$past(full_o)) else protocol_error("write accepted while full");
   a_no_unf: assert property (@(posedge pos_clk) disable iff (!aresetn)
      $rose(rd_ack_o) |-> !$past(empty_o)) else protocol_error("read accepted while empty");
   a_rd_hold: assert property (@(posedge pos_clk) disable iff (!aresetn)
      (rd_ack_o && $past(rd_ack_o)) |-> $stable(rd_data_o))
      else value_error("rd_data_o changed during ack");
   a_cnt_up: assert property (@(posedge pos_clk) disable iff (!aresetn)
      ($rose(wr_ack_o) && !$rose(rd_ack_o)) |-> (count_o == $past(count_o) + 1'b1))
      else value_error("count_o did not step up on write");
   a_cnt_dn: assert property (@(posedge pos_clk) disable iff (!aresetn)
      ($rose(rd_ack_o) && !$rose(wr_ack_o)) |-> (count_o == $past(count_o) - 1'b1))
      else value_error("count_o did not step down on read");
   a_cnt_mdl: assert property (@(posedge pos_clk) disable iff (!aresetn)
      count_o == model_cnt) else value_error("count_o differs from model occupancy");

   // flag rules straight from the thresholds
   a_full: assert property (@(posedge pos_clk) disable iff (!aresetn)
      full_o == (count_o == fifo_geom_pkg::DEPTH)) else value_error("full_o wrong for count_o");
   a_afull: assert property (@(posedge pos_clk) disable iff (!aresetn)
      afull_o == (count_o >= fifo_flag_pkg::AFULL_VAL)) else value_error("afull_o wrong");
   a_empty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      empty_o == (count_o == 0)) else value_error("empty_o wrong for count_o");
   a_aempty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      aempty_o == (count_o <= fifo_flag_pkg::AEMPTY_VAL)) else value_error("aempty_o wrong");

   // ------------------------------------------------------------------
   // model update on the falling edge, outputs settled by then
   // ------------------------------------------------------------------
   always @(negedge pos_clk) begin
      if (aresetn) begin
         if (wr_ack_o && !prev_wr_ack) begin   // push happened at last rising edge
            model_q.push_back(wr_data_i);
            model_cnt++;
         end
         if (rd_ack_o && !prev_rd_ack) begin
            if (model_q.size() == 0) begin
               other_errs++;
               $display("read acknowledged at %0t ns with no word expected", $time);
            end else begin
               exp_word = model_q.pop_front();
               model_cnt--;
               assert (rd_data_o == exp_word)
                  else value_error($sformatf("read %02h, expected %02h", rd_data_o, exp_word));
            end
         end
         seen_cnt[count_o] = 1'b1;
      end
      prev_wr_ack = wr_ack_o;
      prev_rd_ack = rd_ack_o;
   end

   function automatic fifo_geom_pkg::data_t rand_word();
      return fifo_geom_pkg::data_t'($random(seed));
   endfunction

   function automatic int rand_gap();
      return $unsigned($random(seed)) % (GAP_MAX + 1);
   endfunction

   // four-phase write, waits without limit under back-pressure
   task automatic do_write(input fifo_geom_pkg::data_t d);
      @(posedge pos_clk);
      #DRV_DLY;
      wr_data_i = d;
      wr_req_i  = 1'b1;
      while (!wr_ack_o) begin
         @(posedge pos_clk);
         #DRV_DLY;
      end
      repeat (rand_gap()) begin         // source keeps the request a while
         @(posedge pos_clk);
         #DRV_DLY;
      end
      wr_req_i = 1'b0;                  // data stays put until next write
      while (wr_ack_o) begin
         @(posedge pos_clk);
         #DRV_DLY;
      end
   endtask

   task automatic do_read();
      @(posedge pos_clk);
      #DRV_DLY;
      rd_req_i = 1'b1;
      while (!rd_ack_o) begin
         @(posedge pos_clk);
         #DRV_DLY;
      end
      repeat (rand_gap()) begin         // ack and data held over several edges
         @(posedge pos_clk);
         #DRV_DLY;
      end
      rd_req_i = 1'b0;                  // word taken by the monitor
      while (rd_ack_o) begin
         @(posedge pos_clk);
         #DRV_DLY;
      end
   endtask

   task automatic check_reset_state();
      assert (!wr_ack_o && !rd_ack_o) else value_error("ack high after reset");
      assert (count_o == 0) else value_error("count_o not zero after reset");
      assert (empty_o && aempty_o) else value_error("empty flags low after reset");
      assert (!full_o && !afull_o) else value_error("full flags high after reset");
   endtask

   task automatic check_levels_reached();
      int lvl [5] = '{2, 3, 13, 14, 16};
      foreach (lvl[k]) begin
         if (!seen_cnt[lvl[k]]) begin
            other_errs++;
            $display("count level %0d was never reached, flag crossing not exercised", lvl[k]);
         end
      end
   endtask

   // ------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------
   initial begin
      wr_req_i  = 1'b0;
      wr_data_i = '0;
      rd_req_i  = 1'b0;
      @(posedge aresetn);
      @(negedge pos_clk);
      check_reset_state();

      // random interleave, reader stalls on empty by itself
      fork
         for (int i = 0; i < N_RAND; i++) begin
            repeat (rand_gap()) @(posedge pos_clk);
            do_write(rand_word());
         end
         for (int j = 0; j < N_RAND; j++) begin
            repeat (rand_gap()) @(posedge pos_clk);
            do_read();
         end
      join

      // fill, then a blocked 17th write freed by one read
      for (int i = 0; i < fifo_geom_pkg::DEPTH; i++)
         do_write(rand_word());
      assert (full_o) else value_error("full_o low after DEPTH writes");
      fork
         do_write(rand_word());
         begin
            repeat (HOLD_CYC) @(posedge pos_clk);
            #DRV_DLY;
            assert (!wr_ack_o) else value_error("write acknowledged while full");
            do_read();
         end
      join
      for (int i = 0; i < fifo_geom_pkg::DEPTH; i++)
         do_read();

      // blocked read on empty, freed by one write
      fork
         do_read();
         begin
            repeat (HOLD_CYC) @(posedge pos_clk);
            #DRV_DLY;
            assert (!rd_ack_o) else value_error("read acknowledged while empty");
            do_write(rand_word());
         end
      join

      repeat (3) @(posedge pos_clk);
      check_levels_reached();
      if (model_q.size() != 0) begin
         other_errs++;
         $display("%0d written words were never read back", model_q.size());
      end
      $display("summary: %0d value errors, %0d protocol errors, %0d other errors",
               value_errs, proto_errs, other_errs);
      if (value_errs + proto_errs + other_errs == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // watchdog, 1.5 times the summed worst case of all phases
   initial begin
      #(WATCHDOG_NS);
      $display("timeout: run did not finish within %0d ns, a handshake never completed",
               WATCHDOG_NS);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

/* scntr_fifo.f */
hw/fifo_geom_pkg.sv
hw/fifo_flag_pkg.sv
hw/wr_port_ctrl.sv
hw/fifo_store.sv
hw/rd_port_ctrl.sv
hw/scntr_fifo_top.sv
sim/tb_clkgen.sv
sim/tb_scntr_fifo.sv
